// ==== common/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data and instruction word
`define WORD_W 16

// word-addressed memory shared by program, data and stack
`define ADDR_W 8
`define MEM_DEPTH 256

// stack grows upward from here
`define STACK_BASE 224

// general registers ax to dx
`define REG_COUNT 4

`endif

// ==== common/cpuIsaPkg.sv ====
`include "cpu_defines.svh"

package cpuIsaPkg;

	// opcode numbers follow the original instruction set, HLT is new
	typedef enum logic [`WORD_W-1:0] {
		OP_NOP   = 16'h00,
		OP_SCF   = 16'h01,
		OP_CFF   = 16'h02,
		OP_COF   = 16'h03,
		OP_CZF   = 16'h04,
		OP_MOVR  = 16'h07, // reg to reg
		OP_MOVI  = 16'h08, // immediate to reg
		OP_POP   = 16'h09,
		OP_OUT   = 16'h0A,
		OP_PUSH  = 16'h0B,
		OP_ADD   = 16'h0C,
		OP_ADC   = 16'h0D,
		OP_SUB   = 16'h0E,
		OP_SUC   = 16'h0F,
		OP_CMP   = 16'h14,
		OP_AND   = 16'h15,
		OP_NOT   = 16'h17,
		OP_OR    = 16'h18,
		OP_SHL   = 16'h19,
		OP_SHR   = 16'h1A,
		OP_XOR   = 16'h1B,
		OP_JMP   = 16'h20,
		OP_JC    = 16'h21,
		OP_JNC   = 16'h22,
		OP_JZ    = 16'h23,
		OP_JNZ   = 16'h24,
		OP_JO    = 16'h25,
		OP_JNO   = 16'h26,
		OP_IN    = 16'h28,
		OP_MOVST = 16'h2A, // absolute store
		OP_MOVLD = 16'h2B, // absolute load
		OP_HLT   = 16'h3F
	} opcodeE;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SUC, ALU_CMP,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOT, ALU_SHL, ALU_SHR
	} aluOpE;

	typedef enum logic [1:0] {
		REG_AX = 2'd0,
		REG_BX = 2'd1,
		REG_CX = 2'd2,
		REG_DX = 2'd3
	} regSelE;

	typedef enum logic [2:0] {
		IDLE, FETCH, OPERAND, EXECUTE, ALUWAIT, MEMWAIT
	} ctrlStateE;

endpackage

// ==== common/cpuBusPkg.sv ====
`include "cpu_defines.svh"

package cpuBusPkg;

	typedef struct packed {
		logic valid;
		logic write;
		logic [`ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] wdata;
	} memReqT;

	// program load from outside while halted
	typedef struct packed {
		logic valid;
		logic [`ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] data;
	} loadReqT;

	typedef struct packed {
		logic valid;
		cpuIsaPkg::aluOpE op;
		logic [`WORD_W-1:0] a; // destination operand
		logic [`WORD_W-1:0] b;
		logic carryIn;
	} aluReqT;

	typedef struct packed {
		logic valid;
		logic [`WORD_W-1:0] result;
		logic cf;
		logic zf;
		logic of;
	} aluRespT;

	typedef struct packed {
		logic valid;
		logic [`WORD_W-1:0] base; // from bx
		logic [`WORD_W-1:0] data; // from dx
	} portOutT;

endpackage

// ==== source/sharedMemory.sv ====
`include "cpu_defines.svh"

module sharedMemory (
	input logic clk,
	input cpuBusPkg::memReqT memReq,
	input cpuBusPkg::loadReqT loadReq,
	output logic [`WORD_W-1:0] memRdata
);

	logic [`WORD_W-1:0] mem [`MEM_DEPTH]; // program, data and stack

	// single port, the core wins over the loader
	always_ff @(posedge clk) begin
		if (memReq.valid) begin
			if (memReq.write) begin
				mem[memReq.addr] <= memReq.wdata;
			end else begin
				memRdata <= mem[memReq.addr]; // registered read
			end
		end else if (loadReq.valid) begin
			mem[loadReq.addr] <= loadReq.data;
		end
	end

endmodule

// ==== core/alu.sv ====
`include "cpu_defines.svh"

module alu (
	input logic clk,
	input logic reset,
	input cpuBusPkg::aluReqT aluReq,
	output cpuBusPkg::aluRespT aluResp
);

	localparam int Msb = `WORD_W - 1;

	logic [`WORD_W:0] wide; // carry or borrow in the top bit
	logic [`WORD_W:0] carryExt;
	cpuBusPkg::aluRespT nextResp;

	assign carryExt = {{`WORD_W{1'b0}}, aluReq.carryIn};

	always_comb begin
		case (aluReq.op)
			cpuIsaPkg::ALU_ADD: wide = {1'b0, aluReq.a} + {1'b0, aluReq.b};
			cpuIsaPkg::ALU_ADC: wide = {1'b0, aluReq.a} + {1'b0, aluReq.b} + carryExt;
			cpuIsaPkg::ALU_SUB, cpuIsaPkg::ALU_CMP: wide = {1'b0, aluReq.a} - {1'b0, aluReq.b};
			cpuIsaPkg::ALU_SUC: wide = {1'b0, aluReq.a} - {1'b0, aluReq.b} - carryExt;
			cpuIsaPkg::ALU_AND: wide = {1'b0, aluReq.a & aluReq.b};
			cpuIsaPkg::ALU_OR: wide = {1'b0, aluReq.a | aluReq.b};
			cpuIsaPkg::ALU_XOR: wide = {1'b0, aluReq.a ^ aluReq.b};
			cpuIsaPkg::ALU_NOT: wide = {1'b0, ~aluReq.a};
			cpuIsaPkg::ALU_SHL: wide = {aluReq.a, 1'b0}; // msb falls into carry
			cpuIsaPkg::ALU_SHR: wide = {aluReq.a[0], 1'b0, aluReq.a[Msb:1]};
			default: wide = {1'b0, aluReq.a};
		endcase

		nextResp.valid = aluReq.valid;
		nextResp.result = wide[Msb:0];
		nextResp.cf = wide[`WORD_W];
		nextResp.zf = (wide[Msb:0] == '0);

		// signed overflow, sign of result differs from what the operands allow
		case (aluReq.op)
			cpuIsaPkg::ALU_ADD, cpuIsaPkg::ALU_ADC:
				nextResp.of = (aluReq.a[Msb] == aluReq.b[Msb]) && (wide[Msb] != aluReq.a[Msb]);
			cpuIsaPkg::ALU_SUB, cpuIsaPkg::ALU_SUC, cpuIsaPkg::ALU_CMP:
				nextResp.of = (aluReq.a[Msb] != aluReq.b[Msb]) && (wide[Msb] != aluReq.a[Msb]);
			default: nextResp.of = 1'b0;
		endcase
	end

	// one-cycle response
	always_ff @(posedge clk) begin
		aluResp <= nextResp;
		if (!reset) begin
			aluResp.valid <= 1'b0;
		end
	end

endmodule

// ==== core/controlUnit.sv ====
`include "cpu_defines.svh"

module controlUnit (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [`WORD_W-1:0] inData,
	input logic [`WORD_W-1:0] memRdata,
	input cpuBusPkg::aluRespT aluResp,
	output cpuBusPkg::memReqT memReq,
	output cpuBusPkg::aluReqT aluReq,
	output cpuBusPkg::portOutT portOut,
	output logic halted
);

	cpuIsaPkg::ctrlStateE state;
	logic [`REG_COUNT-1:0][`WORD_W-1:0] regFile; // ax, bx, cx, dx
	logic [`ADDR_W-1:0] pc;
	logic [`ADDR_W-1:0] sp;
	logic cf;
	logic zf;
	logic of;
	cpuIsaPkg::opcodeE opcode;
	cpuIsaPkg::opcodeE curOp;
	logic [`WORD_W-1:0] op1;
	logic [`WORD_W-1:0] op2;
	logic [1:0] wordCnt; // index of the word arriving in OPERAND
	cpuIsaPkg::regSelE pairDst;
	cpuIsaPkg::regSelE pairSrc;
	cpuIsaPkg::regSelE storeSrc;
	cpuIsaPkg::aluOpE aluOp;
	logic isAlu;
	logic jumpTaken;

	// operand words following the opcode
	function automatic logic [1:0] operandWords(cpuIsaPkg::opcodeE op);
		case (op)
			cpuIsaPkg::OP_MOVI, cpuIsaPkg::OP_MOVST, cpuIsaPkg::OP_MOVLD: return 2'd2;
			cpuIsaPkg::OP_NOP, cpuIsaPkg::OP_CFF, cpuIsaPkg::OP_COF, cpuIsaPkg::OP_CZF,
			cpuIsaPkg::OP_OUT, cpuIsaPkg::OP_IN, cpuIsaPkg::OP_HLT: return 2'd0;
			cpuIsaPkg::OP_MOVR, cpuIsaPkg::OP_PUSH, cpuIsaPkg::OP_POP, cpuIsaPkg::OP_SCF,
			cpuIsaPkg::OP_ADD, cpuIsaPkg::OP_ADC, cpuIsaPkg::OP_SUB, cpuIsaPkg::OP_SUC,
			cpuIsaPkg::OP_CMP, cpuIsaPkg::OP_AND, cpuIsaPkg::OP_OR, cpuIsaPkg::OP_XOR,
			cpuIsaPkg::OP_NOT, cpuIsaPkg::OP_SHL, cpuIsaPkg::OP_SHR,
			cpuIsaPkg::OP_JMP, cpuIsaPkg::OP_JC, cpuIsaPkg::OP_JNC, cpuIsaPkg::OP_JZ,
			cpuIsaPkg::OP_JNZ, cpuIsaPkg::OP_JO, cpuIsaPkg::OP_JNO: return 2'd1;
			default: return 2'd0; // unknown runs as NOP
		endcase
	endfunction

	assign curOp = (wordCnt == 2'd0) ? cpuIsaPkg::opcodeE'(memRdata) : opcode;
	assign pairDst = cpuIsaPkg::regSelE'(op1[3:2]);
	assign pairSrc = cpuIsaPkg::regSelE'(op1[1:0]); // also the single register field
	assign storeSrc = cpuIsaPkg::regSelE'(op2[1:0]);
	assign halted = (state == cpuIsaPkg::IDLE);

	always_comb begin
		isAlu = 1'b1;
		aluOp = cpuIsaPkg::ALU_ADD;
		case (opcode)
			cpuIsaPkg::OP_ADD: aluOp = cpuIsaPkg::ALU_ADD;
			cpuIsaPkg::OP_ADC: aluOp = cpuIsaPkg::ALU_ADC;
			cpuIsaPkg::OP_SUB: aluOp = cpuIsaPkg::ALU_SUB;
			cpuIsaPkg::OP_SUC: aluOp = cpuIsaPkg::ALU_SUC;
			cpuIsaPkg::OP_CMP: aluOp = cpuIsaPkg::ALU_CMP;
			cpuIsaPkg::OP_AND: aluOp = cpuIsaPkg::ALU_AND;
			cpuIsaPkg::OP_OR: aluOp = cpuIsaPkg::ALU_OR;
			cpuIsaPkg::OP_XOR: aluOp = cpuIsaPkg::ALU_XOR;
			cpuIsaPkg::OP_NOT: aluOp = cpuIsaPkg::ALU_NOT;
			cpuIsaPkg::OP_SHL: aluOp = cpuIsaPkg::ALU_SHL;
			cpuIsaPkg::OP_SHR: aluOp = cpuIsaPkg::ALU_SHR;
			default: isAlu = 1'b0;
		endcase
	end

	always_comb begin
		case (opcode)
			cpuIsaPkg::OP_JMP: jumpTaken = 1'b1;
			cpuIsaPkg::OP_JC: jumpTaken = cf;
			cpuIsaPkg::OP_JNC: jumpTaken = !cf;
			cpuIsaPkg::OP_JZ: jumpTaken = zf;
			cpuIsaPkg::OP_JNZ: jumpTaken = !zf;
			cpuIsaPkg::OP_JO: jumpTaken = of;
			cpuIsaPkg::OP_JNO: jumpTaken = !of;
			default: jumpTaken = 1'b0;
		endcase
	end

	// memory port, read data comes back one cycle later
	always_comb begin
		memReq = '0;
		case (state)
			cpuIsaPkg::FETCH: begin
				memReq.valid = 1'b1;
				memReq.addr = pc;
			end
			cpuIsaPkg::OPERAND: begin
				if (wordCnt == 2'd2 && opcode == cpuIsaPkg::OP_MOVLD) begin
					memReq.valid = 1'b1; // address word is on memRdata now
					memReq.addr = memRdata[`ADDR_W-1:0];
				end
			end
			cpuIsaPkg::EXECUTE: begin
				case (opcode)
					cpuIsaPkg::OP_MOVST: begin
						memReq.valid = 1'b1;
						memReq.write = 1'b1;
						memReq.addr = op1[`ADDR_W-1:0];
						memReq.wdata = regFile[storeSrc];
					end
					cpuIsaPkg::OP_PUSH: begin
						memReq.valid = 1'b1;
						memReq.write = 1'b1;
						memReq.addr = sp;
						memReq.wdata = regFile[pairSrc];
					end
					cpuIsaPkg::OP_POP: begin
						memReq.valid = 1'b1;
						memReq.addr = sp - 1'b1; // pre-decrement read
					end
					default: memReq.valid = 1'b0;
				endcase
			end
			default: memReq.valid = 1'b0;
		endcase
	end

	always_comb begin
		aluReq.valid = (state == cpuIsaPkg::EXECUTE) && isAlu;
		aluReq.op = aluOp;
		aluReq.a = regFile[pairDst];
		aluReq.b = regFile[pairSrc];
		aluReq.carryIn = cf;
		portOut.valid = (state == cpuIsaPkg::EXECUTE) && (opcode == cpuIsaPkg::OP_OUT);
		portOut.base = regFile[cpuIsaPkg::REG_BX];
		portOut.data = regFile[cpuIsaPkg::REG_DX];
	end

	// operand words
	always_ff @(posedge clk) begin
		if (state == cpuIsaPkg::OPERAND && wordCnt == 2'd1) begin
			op1 <= memRdata;
		end
		if (state == cpuIsaPkg::OPERAND && wordCnt == 2'd2) begin
			op2 <= memRdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= cpuIsaPkg::IDLE;
			regFile <= '0;
			pc <= '0;
			sp <= '0;
			cf <= 1'b0;
			zf <= 1'b0;
			of <= 1'b0;
			opcode <= cpuIsaPkg::OP_NOP;
			wordCnt <= '0;
		end else begin
			case (state)
				cpuIsaPkg::IDLE: begin
					if (start) begin
						pc <= '0;
						sp <= `STACK_BASE;
						state <= cpuIsaPkg::FETCH;
					end
				end
				cpuIsaPkg::FETCH: begin
					pc <= pc + 1'b1;
					state <= cpuIsaPkg::OPERAND;
				end
				cpuIsaPkg::OPERAND: begin
					if (wordCnt == 2'd0) begin
						opcode <= curOp;
					end
					if (wordCnt < operandWords(curOp)) begin
						wordCnt <= wordCnt + 1'b1;
						state <= cpuIsaPkg::FETCH; // next operand word
					end else begin
						wordCnt <= '0;
						state <= cpuIsaPkg::EXECUTE;
					end
				end
				cpuIsaPkg::EXECUTE: begin
					state <= cpuIsaPkg::FETCH;
					case (opcode)
						cpuIsaPkg::OP_SCF: cf <= op1[0];
						cpuIsaPkg::OP_CFF: regFile[cpuIsaPkg::REG_DX] <= `WORD_W'(cf);
						cpuIsaPkg::OP_COF: regFile[cpuIsaPkg::REG_DX] <= `WORD_W'(of);
						cpuIsaPkg::OP_CZF: regFile[cpuIsaPkg::REG_DX] <= `WORD_W'(zf);
						cpuIsaPkg::OP_MOVR: regFile[pairDst] <= regFile[pairSrc];
						cpuIsaPkg::OP_MOVI: regFile[pairSrc] <= op2;
						cpuIsaPkg::OP_MOVLD: regFile[pairSrc] <= memRdata;
						cpuIsaPkg::OP_IN: regFile[cpuIsaPkg::REG_DX] <= inData;
						cpuIsaPkg::OP_PUSH: sp <= sp + 1'b1;
						cpuIsaPkg::OP_POP: begin
							sp <= sp - 1'b1;
							state <= cpuIsaPkg::MEMWAIT;
						end
						cpuIsaPkg::OP_JMP, cpuIsaPkg::OP_JC, cpuIsaPkg::OP_JNC,
						cpuIsaPkg::OP_JZ, cpuIsaPkg::OP_JNZ, cpuIsaPkg::OP_JO,
						cpuIsaPkg::OP_JNO: begin
							if (jumpTaken) begin
								pc <= op1[`ADDR_W-1:0];
							end
						end
						cpuIsaPkg::OP_HLT: state <= cpuIsaPkg::IDLE;
						default: begin
							if (isAlu) begin
								state <= cpuIsaPkg::ALUWAIT;
							end
						end
					endcase
				end
				cpuIsaPkg::ALUWAIT: begin
					if (aluResp.valid) begin
						if (opcode != cpuIsaPkg::OP_CMP) begin
							regFile[pairDst] <= aluResp.result;
						end
						cf <= aluResp.cf;
						zf <= aluResp.zf;
						of <= aluResp.of;
					end
					state <= cpuIsaPkg::FETCH;
				end
				cpuIsaPkg::MEMWAIT: begin
					regFile[pairSrc] <= memRdata; // popped word
					state <= cpuIsaPkg::FETCH;
				end
				default: state <= cpuIsaPkg::IDLE;
			endcase
		end
	end

endmodule

// ==== core/cpuCore.sv ====
`include "cpu_defines.svh"

module cpuCore (
	input logic clk,
	input logic reset,
	input logic start,
	input cpuBusPkg::loadReqT loadReq,
	input logic [`WORD_W-1:0] inData,
	output cpuBusPkg::portOutT portOut,
	output logic halted
);

	cpuBusPkg::memReqT memReq;
	cpuBusPkg::aluReqT aluReq;
	cpuBusPkg::aluRespT aluResp;
	logic [`WORD_W-1:0] memRdata;

	sharedMemory sharedMemory_i (
		.clk(clk),
		.memReq(memReq),
		.loadReq(loadReq),
		.memRdata(memRdata)
	);

	controlUnit controlUnit_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.inData(inData),
		.memRdata(memRdata),
		.aluResp(aluResp),
		.memReq(memReq),
		.aluReq(aluReq),
		.portOut(portOut),
		.halted(halted)
	);

	alu alu_i (
		.clk(clk),
		.reset(reset),
		.aluReq(aluReq),
		.aluResp(aluResp)
	);

endmodule

// ==== verification/cpuCore_asserts.sv ====
module cpuCore_asserts (
	input logic clk,
	input logic reset,
	input cpuIsaPkg::ctrlStateE state,
	input logic aluReqValid,
	input logic aluRespValid,
	input logic memReqValid,
	input logic portOutValid,
	input logic halted
);
	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0; // read by the testbench at the end

	aluRespFollows: assert property (@(posedge clk) disable iff (!reset)
		aluRespValid == $past(aluReqValid))
	else begin
		failCount++;
		$error("alu response valid does not follow the request by one cycle");
	end

	noOutWhileHalted: assert property (@(posedge clk) disable iff (!reset)
		halted |-> !portOutValid)
	else begin
		failCount++;
		$error("port output strobe while the core is halted");
	end

	// idle core leaves both ports quiet
	quietInIdle: assert property (@(posedge clk) disable iff (!reset)
		(state == cpuIsaPkg::IDLE) |-> (!aluReqValid && !memReqValid))
	else begin
		failCount++;
		$error("alu or memory request issued in IDLE");
	end

endmodule

bind controlUnit cpuCore_asserts cpuCore_asserts_i (
	.clk(clk),
	.reset(reset),
	.state(state),
	.aluReqValid(aluReq.valid),
	.aluRespValid(aluResp.valid),
	.memReqValid(memReq.valid),
	.portOutValid(portOut.valid),
	.halted(halted)
);

// ==== verification/cpuCore_tb.sv ====
`include "cpu_defines.svh"

module cpuCore_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RunLimit = 2000; // cycles allowed per program

	typedef struct packed {
		logic [`WORD_W-1:0] result;
		logic cf;
		logic zf;
		logic of;
	} flagResultT;

	logic clk;
	logic reset;
	logic start;
	cpuBusPkg::loadReqT loadReq;
	logic [`WORD_W-1:0] inData;
	cpuBusPkg::portOutT portOut;
	logic halted;

	logic [`WORD_W-1:0] prog [$];
	logic [`WORD_W-1:0] outBase [$];
	logic [`WORD_W-1:0] outData [$];
	logic [`WORD_W-1:0] expBase [$];
	logic [`WORD_W-1:0] expData [$];
	int checkCount;
	int errorCount;
	int timeoutCount;
	int assertFails;

	cpuCore cpuCore_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.loadReq(loadReq),
		.inData(inData),
		.portOut(portOut),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// port events, sampled mid-cycle
	always @(negedge clk) begin
		if (portOut.valid) begin
			outBase.push_back(portOut.base);
			outData.push_back(portOut.data);
		end
	end

	function automatic void addWord(logic [`WORD_W-1:0] word);
		prog.push_back(word);
	endfunction

	function automatic void movImm(cpuIsaPkg::regSelE dst, logic [`WORD_W-1:0] value);
		addWord(cpuIsaPkg::OP_MOVI);
		addWord(`WORD_W'(dst));
		addWord(value);
	endfunction

	// dst in bits 3:2, src in bits 1:0
	function automatic void pairOp(cpuIsaPkg::opcodeE op, cpuIsaPkg::regSelE dst,
			cpuIsaPkg::regSelE src);
		addWord(op);
		addWord(`WORD_W'({dst, src}));
	endfunction

	function automatic void singleOp(cpuIsaPkg::opcodeE op, logic [`WORD_W-1:0] operand);
		addWord(op);
		addWord(operand);
	endfunction

	// cf, zf and of copied to dx and sent out in that order
	function automatic void flagOuts();
		addWord(cpuIsaPkg::OP_CFF);
		addWord(cpuIsaPkg::OP_OUT);
		addWord(cpuIsaPkg::OP_CZF);
		addWord(cpuIsaPkg::OP_OUT);
		addWord(cpuIsaPkg::OP_COF);
		addWord(cpuIsaPkg::OP_OUT);
	endfunction

	function automatic void expectEvent(logic [`WORD_W-1:0] base, logic [`WORD_W-1:0] data);
		expBase.push_back(base);
		expData.push_back(data);
	endfunction

	function automatic void newProgram();
		prog.delete();
		expBase.delete();
		expData.delete();
	endfunction

	// marker goes out only when the jump falls through
	function automatic void condJump(cpuIsaPkg::opcodeE op, logic taken,
			logic [`WORD_W-1:0] base, logic [`WORD_W-1:0] marker);
		int patchAt;
		movImm(cpuIsaPkg::REG_DX, marker);
		addWord(op);
		patchAt = prog.size();
		addWord('0);
		addWord(cpuIsaPkg::OP_OUT);
		prog[patchAt] = `WORD_W'(prog.size()); // skip target right after the OUT
		if (!taken) begin
			expectEvent(base, marker);
		end
	endfunction

	// add and subtract family worked out on plain integers
	function automatic flagResultT arithModel(cpuIsaPkg::opcodeE op, logic [`WORD_W-1:0] a,
			logic [`WORD_W-1:0] b, logic cin);
		flagResultT r;
		int carry;
		int uSum;
		int sSum;
		carry = (op == cpuIsaPkg::OP_ADC || op == cpuIsaPkg::OP_SUC) ? int'(cin) : 0;
		if (op == cpuIsaPkg::OP_ADD || op == cpuIsaPkg::OP_ADC) begin
			uSum = int'(a) + int'(b) + carry;
			sSum = int'($signed(a)) + int'($signed(b)) + carry;
			r.cf = (uSum > 65535);
		end else begin
			uSum = int'(a) - int'(b) - carry;
			sSum = int'($signed(a)) - int'($signed(b)) - carry;
			r.cf = (uSum < 0); // borrow
		end
		r.result = `WORD_W'(uSum);
		r.of = (sSum > 32767) || (sSum < -32768);
		r.zf = (r.result == '0);
		return r;
	endfunction

	function automatic flagResultT logicModel(cpuIsaPkg::opcodeE op, logic [`WORD_W-1:0] a,
			logic [`WORD_W-1:0] b);
		flagResultT r;
		r.cf = 1'b0;
		r.of = 1'b0;
		case (op)
			cpuIsaPkg::OP_AND: r.result = a & b;
			cpuIsaPkg::OP_OR: r.result = a | b;
			cpuIsaPkg::OP_XOR: r.result = a ^ b;
			cpuIsaPkg::OP_NOT: r.result = ~a;
			cpuIsaPkg::OP_SHL: begin
				r.result = a << 1;
				r.cf = a[`WORD_W-1];
			end
			cpuIsaPkg::OP_SHR: begin
				r.result = a >> 1;
				r.cf = a[0];
			end
			default: r.result = a;
		endcase
		r.zf = (r.result == '0);
		return r;
	endfunction

	task automatic loadProgram();
		foreach (prog[i]) begin
			@(negedge clk);
			loadReq.valid = 1'b1;
			loadReq.addr = `ADDR_W'(i);
			loadReq.data = prog[i];
		end
		@(negedge clk);
		loadReq = '0;
	endtask

	task automatic runProgram();
		int cycles;
		outBase.delete();
		outData.delete();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		checkCount++;
		assert (halted == 1'b0) else begin
			errorCount++;
			$display("mismatch at %0t ns: halted still high after start", $time);
		end
		cycles = 0;
		while (!halted && cycles < RunLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			timeoutCount++;
			$display("timeout at %0t ns: the core did not halt within %0d cycles",
				$time, RunLimit);
		end
	endtask

	task automatic checkOutputs(input string name);
		checkCount++;
		assert (outData.size() == expData.size()) else begin
			errorCount++;
			$display("mismatch at %0t ns: %s gave %0d port events, expected %0d",
				$time, name, outData.size(), expData.size());
		end
		foreach (expData[i]) begin
			if (i < outData.size()) begin
				checkCount++;
				assert (outBase[i] == expBase[i] && outData[i] == expData[i]) else begin
					errorCount++;
					$display("mismatch at %0t ns: %s event %0d is %h/%h, expected %h/%h",
						$time, name, i, outBase[i], outData[i], expBase[i], expData[i]);
				end
			end
		end
	endtask

	task automatic runAndCheck(input string name);
		if (timeoutCount == 0) begin
			loadProgram();
			runProgram();
			if (timeoutCount == 0) begin
				checkOutputs(name);
			end
		end
	endtask

	task automatic moveTest();
		logic [`WORD_W-1:0] a;
		logic [`WORD_W-1:0] b;
		logic [`WORD_W-1:0] c;
		logic [`WORD_W-1:0] d;
		a = `WORD_W'($urandom);
		b = `WORD_W'($urandom);
		c = `WORD_W'($urandom);
		d = `WORD_W'($urandom);
		newProgram();
		movImm(cpuIsaPkg::REG_BX, b);
		movImm(cpuIsaPkg::REG_AX, a);
		pairOp(cpuIsaPkg::OP_MOVR, cpuIsaPkg::REG_DX, cpuIsaPkg::REG_AX);
		addWord(cpuIsaPkg::OP_OUT);
		movImm(cpuIsaPkg::REG_CX, c);
		pairOp(cpuIsaPkg::OP_MOVR, cpuIsaPkg::REG_BX, cpuIsaPkg::REG_CX);
		movImm(cpuIsaPkg::REG_DX, d);
		addWord(cpuIsaPkg::OP_OUT);
		pairOp(cpuIsaPkg::OP_MOVR, cpuIsaPkg::REG_AX, cpuIsaPkg::REG_BX); // chain through ax
		pairOp(cpuIsaPkg::OP_MOVR, cpuIsaPkg::REG_DX, cpuIsaPkg::REG_AX);
		addWord(cpuIsaPkg::OP_OUT);
		addWord(cpuIsaPkg::OP_HLT);
		expectEvent(b, a);
		expectEvent(c, d);
		expectEvent(c, c);
		runAndCheck("moves");
	endtask

	task automatic arithTest();
		cpuIsaPkg::opcodeE ops [5];
		flagResultT exp;
		logic [`WORD_W-1:0] a;
		logic [`WORD_W-1:0] b;
		logic cin;
		int round;
		ops = '{cpuIsaPkg::OP_ADD, cpuIsaPkg::OP_ADC, cpuIsaPkg::OP_SUB, cpuIsaPkg::OP_SUC,
			cpuIsaPkg::OP_CMP};
		for (round = 0; round < 3; round++) begin
			foreach (ops[k]) begin
				a = `WORD_W'($urandom);
				b = (round == 0) ? a : `WORD_W'($urandom); // equal operands reach zero
				cin = 1'($urandom);
				exp = arithModel(ops[k], a, b, cin);
				newProgram();
				singleOp(cpuIsaPkg::OP_SCF, `WORD_W'(cin));
				movImm(cpuIsaPkg::REG_AX, a);
				movImm(cpuIsaPkg::REG_CX, b);
				pairOp(ops[k], cpuIsaPkg::REG_AX, cpuIsaPkg::REG_CX);
				movImm(cpuIsaPkg::REG_BX, `WORD_W'(k));
				pairOp(cpuIsaPkg::OP_MOVR, cpuIsaPkg::REG_DX, cpuIsaPkg::REG_AX);
				addWord(cpuIsaPkg::OP_OUT);
				flagOuts();
				addWord(cpuIsaPkg::OP_HLT);
				expectEvent(`WORD_W'(k), (ops[k] == cpuIsaPkg::OP_CMP) ? a : exp.result);
				expectEvent(`WORD_W'(k), `WORD_W'(exp.cf));
				expectEvent(`WORD_W'(k), `WORD_W'(exp.zf));
				expectEvent(`WORD_W'(k), `WORD_W'(exp.of));
				runAndCheck($sformatf("%s round %0d", ops[k].name(), round));
			end
		end
	endtask

	task automatic logicTest();
		cpuIsaPkg::opcodeE ops [6];
		flagResultT exp;
		logic [`WORD_W-1:0] a;
		logic [`WORD_W-1:0] b;
		int round;
		ops = '{cpuIsaPkg::OP_AND, cpuIsaPkg::OP_OR, cpuIsaPkg::OP_XOR, cpuIsaPkg::OP_NOT,
			cpuIsaPkg::OP_SHL, cpuIsaPkg::OP_SHR};
		for (round = 0; round < 2; round++) begin
			foreach (ops[k]) begin
				a = `WORD_W'($urandom);
				b = `WORD_W'($urandom);
				exp = logicModel(ops[k], a, b);
				newProgram();
				singleOp(cpuIsaPkg::OP_SCF, 1); // must be cleared or replaced by the op
				movImm(cpuIsaPkg::REG_AX, a);
				movImm(cpuIsaPkg::REG_CX, b);
				pairOp(ops[k], cpuIsaPkg::REG_AX, cpuIsaPkg::REG_CX);
				movImm(cpuIsaPkg::REG_BX, `WORD_W'(8 + k));
				pairOp(cpuIsaPkg::OP_MOVR, cpuIsaPkg::REG_DX, cpuIsaPkg::REG_AX);
				addWord(cpuIsaPkg::OP_OUT);
				flagOuts();
				addWord(cpuIsaPkg::OP_HLT);
				expectEvent(`WORD_W'(8 + k), exp.result);
				expectEvent(`WORD_W'(8 + k), `WORD_W'(exp.cf));
				expectEvent(`WORD_W'(8 + k), `WORD_W'(exp.zf));
				expectEvent(`WORD_W'(8 + k), `WORD_W'(exp.of));
				runAndCheck($sformatf("%s round %0d", ops[k].name(), round));
			end
		end
	endtask

	task automatic memoryTest();
		logic [`WORD_W-1:0] addr;
		logic [`WORD_W-1:0] v;
		logic [`WORD_W-1:0] p1;
		logic [`WORD_W-1:0] p2;
		addr = `WORD_W'(128 + $urandom_range(0, 95)); // data area below the stack
		v = `WORD_W'($urandom);
		p1 = `WORD_W'($urandom);
		p2 = `WORD_W'($urandom);
		newProgram();
		movImm(cpuIsaPkg::REG_AX, v);
		addWord(cpuIsaPkg::OP_MOVST);
		addWord(addr);
		addWord(`WORD_W'(cpuIsaPkg::REG_AX));
		movImm(cpuIsaPkg::REG_AX, '0);
		addWord(cpuIsaPkg::OP_MOVLD);
		addWord(`WORD_W'(cpuIsaPkg::REG_DX));
		addWord(addr);
		movImm(cpuIsaPkg::REG_BX, 1);
		addWord(cpuIsaPkg::OP_OUT);
		pairOp(cpuIsaPkg::OP_MOVR, cpuIsaPkg::REG_DX, cpuIsaPkg::REG_AX);
		addWord(cpuIsaPkg::OP_OUT);
		movImm(cpuIsaPkg::REG_AX, p1);
		movImm(cpuIsaPkg::REG_CX, p2);
		singleOp(cpuIsaPkg::OP_PUSH, `WORD_W'(cpuIsaPkg::REG_AX));
		singleOp(cpuIsaPkg::OP_PUSH, `WORD_W'(cpuIsaPkg::REG_CX));
		movImm(cpuIsaPkg::REG_BX, 2);
		singleOp(cpuIsaPkg::OP_POP, `WORD_W'(cpuIsaPkg::REG_DX));
		addWord(cpuIsaPkg::OP_OUT);
		singleOp(cpuIsaPkg::OP_POP, `WORD_W'(cpuIsaPkg::REG_DX));
		addWord(cpuIsaPkg::OP_OUT);
		addWord(cpuIsaPkg::OP_HLT);
		expectEvent(1, v);
		expectEvent(1, 0);
		expectEvent(2, p2); // last in, first out
		expectEvent(2, p1);
		runAndCheck("memory and stack");
	endtask

	task automatic branchTest();
		logic [`WORD_W-1:0] n;
		logic [`WORD_W-1:0] loopTop;
		logic [`WORD_W-1:0] a;
		flagResultT sum;
		logic ovf;
		int i;
		int f;
		n = `WORD_W'($urandom_range(2, 6));
		newProgram();
		movImm(cpuIsaPkg::REG_CX, n);
		movImm(cpuIsaPkg::REG_AX, 1);
		movImm(cpuIsaPkg::REG_BX, 5);
		loopTop = `WORD_W'(prog.size());
		pairOp(cpuIsaPkg::OP_MOVR, cpuIsaPkg::REG_DX, cpuIsaPkg::REG_CX);
		addWord(cpuIsaPkg::OP_OUT);
		pairOp(cpuIsaPkg::OP_SUB, cpuIsaPkg::REG_CX, cpuIsaPkg::REG_AX);
		singleOp(cpuIsaPkg::OP_JNZ, loopTop);
		for (i = int'(n); i > 0; i--) begin
			expectEvent(5, `WORD_W'(i));
		end
		movImm(cpuIsaPkg::REG_BX, 6);
		for (f = 0; f < 2; f++) begin
			singleOp(cpuIsaPkg::OP_SCF, `WORD_W'(f));
			condJump(cpuIsaPkg::OP_JC, f == 1, 6, `WORD_W'(16'hC0 + f));
			condJump(cpuIsaPkg::OP_JNC, f == 0, 6, `WORD_W'(16'hD0 + f));
		end
		// overflow comes from an add, 7fff plus one sets it
		for (f = 0; f < 2; f++) begin
			a = (f == 1) ? 16'h7FFF : 16'h1234;
			sum = arithModel(cpuIsaPkg::OP_ADD, a, 1, 1'b0);
			ovf = sum.of;
			movImm(cpuIsaPkg::REG_AX, a);
			movImm(cpuIsaPkg::REG_CX, 1);
			pairOp(cpuIsaPkg::OP_ADD, cpuIsaPkg::REG_AX, cpuIsaPkg::REG_CX);
			condJump(cpuIsaPkg::OP_JO, ovf, 6, `WORD_W'(16'hE0 + f));
			condJump(cpuIsaPkg::OP_JNO, !ovf, 6, `WORD_W'(16'hF0 + f));
		end
		addWord(cpuIsaPkg::OP_HLT);
		runAndCheck("branches");
	endtask

	task automatic inputTest();
		logic [`WORD_W-1:0] first;
		logic [`WORD_W-1:0] second;
		first = `WORD_W'($urandom);
		second = ~first;
		newProgram();
		movImm(cpuIsaPkg::REG_BX, 16'h0B);
		addWord(cpuIsaPkg::OP_IN);
		addWord(cpuIsaPkg::OP_OUT);
		addWord(cpuIsaPkg::OP_HLT);
		inData = first;
		expectEvent(16'h0B, first);
		runAndCheck("input");
		if (timeoutCount == 0) begin
			expBase.delete();
			expData.delete();
			inData = second; // same program, started again from address 0
			expectEvent(16'h0B, second);
			runProgram();
			if (timeoutCount == 0) begin
				checkOutputs("input rerun");
			end
		end
	endtask

	initial begin
		void'($urandom(66));
		checkCount = 0;
		errorCount = 0;
		timeoutCount = 0;
		reset = 1'b0;
		start = 1'b0;
		loadReq = '0;
		inData = '0;
		repeat (10) @(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		checkCount++;
		assert (halted == 1'b1 && portOut.valid == 1'b0) else begin
			errorCount++;
			$display("mismatch at %0t ns: core not idle after reset", $time);
		end
		moveTest();
		arithTest();
		logicTest();
		memoryTest();
		branchTest();
		inputTest();
		assertFails = cpuCore_i.controlUnit_i.cpuCore_asserts_i.failCount;
		$display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			checkCount, errorCount, timeoutCount, assertFails);
		if (errorCount == 0 && timeoutCount == 0 && assertFails == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+common
common/cpuIsaPkg.sv
common/cpuBusPkg.sv
source/sharedMemory.sv
core/alu.sv
core/controlUnit.sv
core/cpuCore.sv
verification/cpuCore_asserts.sv
verification/cpuCore_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpuCore testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module cpuCore_tb -o simv \
	|| { echo "build failed"; exit 1; }
simOut=$(./obj_dir/simv +verilator+error+limit+100)
echo "$simOut"
echo "$simOut" | grep -qxF "RESULT: PASS" && echo "run passed" || { echo "run failed"; exit 1; }
